// ==== logic/dsp_macros.svh ====
// DSP core size macros
// Address widths for the program and data stores, plus the data path
// and accumulator widths shared by every unit of the core

`ifndef DSP_MACROS_SVH
`define DSP_MACROS_SVH

// Program store address, 256 instruction words
`define DSP_ROM_AW 8

// Data RAM address, 16 data words
`define DSP_RAM_AW 4

// Data word and instruction word
`define DSP_DATA_W 16

// Accumulator with guard bits over the 32-bit product
`define DSP_ACC_W 36

`endif

// ==== logic/dsp_isa_pkg.sv ====
// DSP instruction set
// Opcodes, register codes and the two views of an instruction word

`include "dsp_macros.svh"

package dsp_isa_pkg;

    // Values 9 to 15 are illegal
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        GOTO = 4'd1,
        LDI  = 4'd2,
        STR  = 4'd3,
        LDR  = 4'd4,
        MAC  = 4'd5,
        OUT  = 4'd6,
        HALT = 4'd7,
        CLR  = 4'd8
    } opcode_t;

    // Codes 6 and 7 are reserved
    typedef enum logic [2:0] {
        R0 = 3'd0,
        R1 = 3'd1,
        R2 = 3'd2,
        R3 = 3'd3,
        X  = 3'd4,
        Y  = 3'd5
    } reg_code_t;

    typedef struct packed {
        opcode_t     op;
        logic [11:0] ja;    // only the low ROM address bits matter
    } jump_view_t;

    typedef struct packed {
        opcode_t           op;
        reg_code_t         r_field;
        logic signed [8:0] imm;
    } data_view_t;

    // GOTO reads the jump view, everything else the data view
    typedef union packed {
        jump_view_t jmp;
        data_view_t dat;
    } instr_word_t;

endpackage

// ==== logic/dsp_bus_pkg.sv ====
// DSP control buses
// Strobe bundles sent from the instruction decoder to the execution units

`include "dsp_macros.svh"

package dsp_bus_pkg;

    // Program sequencing
    typedef struct packed {
        logic                   jump;
        logic [`DSP_ROM_AW-1:0] jump_addr;
        logic                   halt;
    } fetch_ctl_t;

    // Pointer registers and data RAM
    typedef struct packed {
        logic                   ptr_load;
        logic [1:0]             ptr_sel;
        logic                   we;
        logic                   rd_use;
        logic [`DSP_RAM_AW-1:0] imm;
    } ram_ctl_t;

    // Data arithmetic unit
    typedef struct packed {
        logic                   x_load;
        logic                   y_load_imm;
        logic                   y_load_ram;
        logic                   mac;
        logic                   clr;
        logic [`DSP_DATA_W-1:0] imm;    // already sign extended
    } dau_ctl_t;

endpackage

// ==== logic/dsp_rom_aau.sv ====
// ROM address unit
// Program counter sequencing and the 256-word program store. The store
// is loaded through the programming port while the core sits in reset
// and is read combinationally at the current program counter

`timescale 1ns/10ps

`include "dsp_macros.svh"

module dsp_rom_aau (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clk_en,
    input  dsp_bus_pkg::fetch_ctl_t  fetch,
    input  logic [`DSP_ROM_AW-1:0]   prog_addr,
    input  logic [`DSP_DATA_W-1:0]   prog_data,
    input  logic                     prog_we,
    output dsp_isa_pkg::instr_word_t instr
);

    localparam int ROM_DEPTH = 1 << `DSP_ROM_AW;

    logic [`DSP_ROM_AW-1:0] pc;
    logic [`DSP_ROM_AW-1:0] pc_next;
    logic [`DSP_DATA_W-1:0] prog_mem [ROM_DEPTH];

    // Jump wins over the halt hold
    always_comb begin
        if (fetch.jump) begin
            pc_next = fetch.jump_addr;
        end else if (fetch.halt) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 1'b1;    // wraps at the top of the store
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (clk_en) begin
            pc <= pc_next;
        end
    end

    // Programming port only accepted in reset
    always_ff @(posedge clk) begin
        if (!rst_n && prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    assign instr = prog_mem[pc];

endmodule

// ==== logic/dsp_ctrl.sv ====
// Instruction decoder
// Turns the current instruction word into load and select strobes for
// the execution units. Keeps the sticky halted and fault state

`timescale 1ns/10ps

`include "dsp_macros.svh"

module dsp_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clk_en,
    input  dsp_isa_pkg::instr_word_t instr,
    output dsp_bus_pkg::fetch_ctl_t  fetch,
    output dsp_bus_pkg::ram_ctl_t    ram_ctl,
    output dsp_bus_pkg::dau_ctl_t    dau_ctl,
    output logic                     out_load,
    output logic                     halted,
    output logic                     fault
);

    import dsp_isa_pkg::*;

    logic                   run;
    logic                   dec_goto;
    logic                   dec_ldi_ptr;
    logic                   dec_ldi_x;
    logic                   dec_ldi_y;
    logic                   dec_str;
    logic                   dec_ldr;
    logic                   dec_mac;
    logic                   dec_clr;
    logic                   dec_out;
    logic                   dec_halt;
    logic                   dec_bad;
    logic [`DSP_DATA_W-1:0] imm_ext;

    assign run = clk_en & ~halted;
    assign imm_ext = {{(`DSP_DATA_W-9){instr.dat.imm[8]}}, instr.dat.imm};

    always_comb begin
        dec_goto    = 1'b0;
        dec_ldi_ptr = 1'b0;
        dec_ldi_x   = 1'b0;
        dec_ldi_y   = 1'b0;
        dec_str     = 1'b0;
        dec_ldr     = 1'b0;
        dec_mac     = 1'b0;
        dec_clr     = 1'b0;
        dec_out     = 1'b0;
        dec_halt    = 1'b0;
        dec_bad     = 1'b0;
        case (instr.jmp.op)
            NOP:  ;
            GOTO: dec_goto = 1'b1;
            LDI: begin
                case (instr.dat.r_field)
                    R0, R1, R2, R3: dec_ldi_ptr = 1'b1;
                    X:              dec_ldi_x   = 1'b1;
                    Y:              dec_ldi_y   = 1'b1;
                    default:        dec_bad     = 1'b1;
                endcase
            end
            STR:  dec_str  = 1'b1;
            LDR:  dec_ldr  = 1'b1;
            MAC:  dec_mac  = 1'b1;
            OUT:  dec_out  = 1'b1;
            HALT: dec_halt = 1'b1;
            CLR:  dec_clr  = 1'b1;
            default: dec_bad = 1'b1;
        endcase
    end

    // Every strobe dies with clk_en low or once halted
    always_comb begin
        fetch.jump         = run & dec_goto;
        fetch.jump_addr    = instr.jmp.ja[`DSP_ROM_AW-1:0];
        fetch.halt         = halted | (run & (dec_halt | dec_bad));
        ram_ctl.ptr_load   = run & dec_ldi_ptr;
        ram_ctl.ptr_sel    = instr.dat.r_field[1:0];
        ram_ctl.we         = run & dec_str;
        ram_ctl.rd_use     = run & dec_ldr;
        ram_ctl.imm        = instr.dat.imm[`DSP_RAM_AW-1:0];
        dau_ctl.x_load     = run & dec_ldi_x;
        dau_ctl.y_load_imm = run & dec_ldi_y;
        dau_ctl.y_load_ram = run & dec_ldr;
        dau_ctl.mac        = run & dec_mac;
        dau_ctl.clr        = run & dec_clr;
        dau_ctl.imm        = imm_ext;
        out_load           = run & dec_out;
    end

    // Both flags are sticky until the next reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
            fault  <= 1'b0;
        end else if (run) begin
            if (dec_halt || dec_bad) begin
                halted <= 1'b1;
            end
            if (dec_bad) begin
                fault <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/dsp_ram_aau.sv ====
// RAM address unit
// Four pointer registers with post-increment and the 16-word data RAM.
// The selected pointer addresses the RAM for both stores and loads

`timescale 1ns/10ps

`include "dsp_macros.svh"

module dsp_ram_aau (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  dsp_bus_pkg::ram_ctl_t  ctl,
    input  logic [`DSP_DATA_W-1:0] st_data,
    output logic [`DSP_DATA_W-1:0] ram_dout
);

    localparam int RAM_DEPTH = 1 << `DSP_RAM_AW;

    logic [`DSP_RAM_AW-1:0] ptr [4];
    logic [`DSP_RAM_AW-1:0] ram_addr;
    logic [`DSP_DATA_W-1:0] ram [RAM_DEPTH];

    assign ram_addr = ptr[ctl.ptr_sel];
    assign ram_dout = ram[ram_addr];

    // Pointers wrap naturally at the RAM size
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                ptr[i] <= '0;
            end
        end else if (clk_en) begin
            if (ctl.ptr_load) begin
                ptr[ctl.ptr_sel] <= ctl.imm;
            end else if (ctl.we || ctl.rd_use) begin
                ptr[ctl.ptr_sel] <= ram_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en && ctl.we) begin
            ram[ram_addr] <= st_data;
        end
    end

endmodule

// ==== logic/dsp_dau.sv ====
// Data arithmetic unit
// Holds x, y and accumulator a0. MAC multiplies x by y
// and adds the signed product into a0 on the same edge

`timescale 1ns/10ps

`include "dsp_macros.svh"

module dsp_dau (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  dsp_bus_pkg::dau_ctl_t  ctl,
    input  logic [`DSP_DATA_W-1:0] ram_dout,
    output logic [`DSP_DATA_W-1:0] acc_dout
);

    logic signed [`DSP_DATA_W-1:0]   x;
    logic signed [`DSP_DATA_W-1:0]   y;
    logic signed [2*`DSP_DATA_W-1:0] prod;
    logic signed [`DSP_ACC_W-1:0]    a0;

    assign prod = x * y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x  <= '0;
            y  <= '0;
            a0 <= '0;
        end else if (clk_en) begin
            if (ctl.x_load) begin
                x <= ctl.imm;
            end
            if (ctl.y_load_imm) begin
                y <= ctl.imm;
            end else if (ctl.y_load_ram) begin
                y <= ram_dout;
            end
            if (ctl.clr) begin
                a0 <= '0;
            end else if (ctl.mac) begin
                // Product sign extended into the guard bits
                a0 <= a0 + {{(`DSP_ACC_W-2*`DSP_DATA_W){prod[2*`DSP_DATA_W-1]}}, prod};
            end
        end
    end

    assign acc_dout = a0[`DSP_DATA_W-1:0];

endmodule

// ==== logic/dsp_pio.sv ====
// Parallel output port
// Latches the accumulator low word onto pbus_out and pulses pods_n low
// for one enabled cycle per OUT

`timescale 1ns/10ps

`include "dsp_macros.svh"

module dsp_pio (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  logic                   out_load,
    input  logic [`DSP_DATA_W-1:0] acc_dout,
    output logic [`DSP_DATA_W-1:0] pbus_out,
    output logic                   pods_n
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pbus_out <= '0;
            pods_n   <= 1'b1;
        end else if (clk_en) begin
            // Strobe follows out_load, so back-to-back OUTs stay low
            pods_n <= ~out_load;
            if (out_load) begin
                pbus_out <= acc_dout;
            end
        end
    end

endmodule

// ==== logic/dsp_top.sv ====
// DSP core top level
// Connects the decoder, the ROM and RAM address units, the data
// arithmetic unit and the parallel output port

`timescale 1ns/10ps

`include "dsp_macros.svh"

module dsp_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    // ROM programming interface
    input  logic [`DSP_ROM_AW-1:0] prog_addr,
    input  logic [`DSP_DATA_W-1:0] prog_data,
    input  logic                   prog_we,
    // Parallel output
    output logic [`DSP_DATA_W-1:0] pbus_out,
    output logic                   pods_n,
    // Status
    output logic                   halted,
    output logic                   fault
);

    import dsp_isa_pkg::*;
    import dsp_bus_pkg::*;

    instr_word_t            instr;
    fetch_ctl_t             fetch;
    ram_ctl_t               ram_ctl;
    dau_ctl_t               dau_ctl;
    logic                   out_load;
    logic [`DSP_DATA_W-1:0] ram_dout;
    logic [`DSP_DATA_W-1:0] acc_dout;

    dsp_rom_aau u_rom_aau (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .clk_en     ( clk_en    ),
        .fetch      ( fetch     ),
        .prog_addr  ( prog_addr ),
        .prog_data  ( prog_data ),
        .prog_we    ( prog_we   ),
        .instr      ( instr     )
    );

    dsp_ctrl u_ctrl (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .clk_en     ( clk_en    ),
        .instr      ( instr     ),
        .fetch      ( fetch     ),
        .ram_ctl    ( ram_ctl   ),
        .dau_ctl    ( dau_ctl   ),
        .out_load   ( out_load  ),
        .halted     ( halted    ),
        .fault      ( fault     )
    );

    // Stores take the accumulator low word
    dsp_ram_aau u_ram_aau (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .clk_en     ( clk_en    ),
        .ctl        ( ram_ctl   ),
        .st_data    ( acc_dout  ),
        .ram_dout   ( ram_dout  )
    );

    dsp_dau u_dau (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .clk_en     ( clk_en    ),
        .ctl        ( dau_ctl   ),
        .ram_dout   ( ram_dout  ),
        .acc_dout   ( acc_dout  )
    );

    dsp_pio u_pio (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .clk_en     ( clk_en    ),
        .out_load   ( out_load  ),
        .acc_dout   ( acc_dout  ),
        .pbus_out   ( pbus_out  ),
        .pods_n     ( pods_n    )
    );

endmodule

// ==== test/dsp_properties.sv ====
// DSP core strobe and status properties
// Bound into the core top level

`timescale 1ns/10ps

module dsp_properties (
    input logic clk,
    input logic rst_n,
    input logic clk_en,
    input logic pods_n,
    input logic halted,
    input logic fault
);

    int fail_count = 0;

    pods_high_in_reset: assert property (@(posedge clk) !rst_n |=> pods_n)
        else begin
            $error("pods_n low during reset");
            fail_count++;
        end

    // Strobe may only start on an enabled edge
    pods_fall_enabled: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(pods_n) |-> $past(clk_en))
        else begin
            $error("pods_n fell without clk_en");
            fail_count++;
        end

    fault_needs_halt: assert property (@(posedge clk) disable iff (!rst_n) fault |-> halted)
        else begin
            $error("fault set while not halted");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) $past(rst_n) |-> !$fell(halted))
        else begin
            $error("halted cleared outside reset");
            fail_count++;
        end

endmodule

bind dsp_top dsp_properties props_i (
    .clk    ( clk    ),
    .rst_n  ( rst_n  ),
    .clk_en ( clk_en ),
    .pods_n ( pods_n ),
    .halted ( halted ),
    .fault  ( fault  )
);

// ==== test/dsp_checker.sv ====
// DSP core output checker
// Collects the expected OUT values during reset, then compares pbus_out
// at every enabled edge with pods_n low, and checks the final status

`timescale 1ns/10ps

`include "dsp_macros.svh"

module dsp_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  logic [`DSP_DATA_W-1:0] pbus_out,
    input  logic                   pods_n,
    input  logic                   halted,
    input  logic                   fault,
    input  logic                   exp_valid,
    input  logic [`DSP_DATA_W-1:0] exp_data,
    input  logic                   exp_fault,
    output logic                   run_done,
    output int                     err_count
);

    logic [`DSP_DATA_W-1:0] exp_q[$];
    logic [`DSP_DATA_W-1:0] exp_v;
    logic                   halted_d;
    int                     errors = 0;

    assign err_count = errors;

    always @(posedge clk) begin
        if (!rst_n) begin
            run_done <= 1'b0;
            halted_d <= 1'b0;
            if (exp_valid) begin
                exp_q.push_back(exp_data);
            end
        end else begin
            // Strobe stays low until the next enabled edge
            if (clk_en && !pods_n) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("t=%0t: output strobe seen with no value left to expect", $time);
                end else begin
                    exp_v = exp_q.pop_front();
                    if (pbus_out !== exp_v) begin
                        errors++;
                        $display("[FAIL] t=%0t pbus_out expected %h actual %h",
                                 $time, exp_v, pbus_out);
                    end
                end
            end
            if (halted && !halted_d) begin
                if (exp_q.size() != 0) begin
                    errors++;
                    $display("t=%0t: core stopped with %0d outputs still missing",
                             $time, exp_q.size());
                    exp_q.delete();
                end
                if (fault !== exp_fault) begin
                    errors++;
                    $display("[FAIL] t=%0t fault expected %b actual %b", $time, exp_fault, fault);
                end
                run_done <= 1'b1;
            end
            halted_d <= halted;
        end
    end

endmodule

// ==== test/dsp_tb.sv ====
// DSP core testbench
// Assembles five programs and loads each one through the programming port
// during reset. A reference interpreter predicts the OUT values and the
// final status, which the checker compares against the core

`timescale 1ns/10ps

`include "dsp_macros.svh"

module dsp_tb;

    import dsp_isa_pkg::*;

    localparam int N_TESTS   = 5;
    localparam int ROM_WORDS = 1 << `DSP_ROM_AW;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   clk_en;
    logic [`DSP_ROM_AW-1:0] prog_addr;
    logic [`DSP_DATA_W-1:0] prog_data;
    logic                   prog_we;
    logic [`DSP_DATA_W-1:0] pbus_out;
    logic                   pods_n;
    logic                   halted;
    logic                   fault;

    // Expected values go to the checker one per cycle in reset
    logic                   exp_valid;
    logic [`DSP_DATA_W-1:0] exp_data;
    logic                   exp_fault;
    logic                   run_done;
    int                     chk_errors;

    logic [`DSP_DATA_W-1:0] progs [N_TESTS][ROM_WORDS];
    int                     prog_len [N_TESTS];
    int                     seed = 32'hd6ea;
    int                     tb_errors = 0;
    int                     cycles = 0;
    int                     cycle_limit = 0;

    always #5 clk = ~clk;

    dsp_top dut_i (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .clk_en    ( clk_en    ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .pbus_out  ( pbus_out  ),
        .pods_n    ( pods_n    ),
        .halted    ( halted    ),
        .fault     ( fault     )
    );

    dsp_checker chk_i (
        .clk       ( clk        ),
        .rst_n     ( rst_n      ),
        .clk_en    ( clk_en     ),
        .pbus_out  ( pbus_out   ),
        .pods_n    ( pods_n     ),
        .halted    ( halted     ),
        .fault     ( fault      ),
        .exp_valid ( exp_valid  ),
        .exp_data  ( exp_data   ),
        .exp_fault ( exp_fault  ),
        .run_done  ( run_done   ),
        .err_count ( chk_errors )
    );

    function automatic logic [`DSP_DATA_W-1:0] data_word(opcode_t op, reg_code_t r,
                                                         logic [8:0] imm);
        instr_word_t w;
        w.dat.op      = op;
        w.dat.r_field = r;
        w.dat.imm     = imm;
        return w;
    endfunction

    function automatic logic [`DSP_DATA_W-1:0] op_word(opcode_t op);
        return data_word(op, R0, 9'd0);
    endfunction

    function automatic logic [`DSP_DATA_W-1:0] jump_word(logic [`DSP_ROM_AW-1:0] target);
        instr_word_t w;
        w.jmp.op = GOTO;
        w.jmp.ja = 12'(target);
        return w;
    endfunction

    function automatic logic [8:0] rand_imm();
        return 9'($random(seed));
    endfunction

    function automatic void append_word(int p, logic [`DSP_DATA_W-1:0] w);
        progs[p][prog_len[p]] = w;
        prog_len[p]++;
    endfunction

    // Instruction set interpreter over one program image
    function automatic void ref_run(input int p, output logic [`DSP_DATA_W-1:0] outs[$],
                                    output logic end_halt, output logic end_fault);
        instr_word_t            w;
        logic [`DSP_ROM_AW-1:0] pc;
        logic [`DSP_RAM_AW-1:0] ptr [4];
        logic [`DSP_DATA_W-1:0] ram [1 << `DSP_RAM_AW];
        logic [`DSP_RAM_AW-1:0] addr;
        logic [1:0]             sel;
        logic signed [15:0]     x;
        logic signed [15:0]     y;
        logic signed [31:0]     prod;
        logic signed [35:0]     a0;
        int                     steps;
        outs      = {};
        end_halt  = 1'b0;
        end_fault = 1'b0;
        pc        = '0;
        x         = '0;
        y         = '0;
        a0        = '0;
        steps     = 0;
        foreach (ptr[i]) ptr[i] = '0;
        foreach (ram[i]) ram[i] = '0;
        while (!end_halt && steps < 4 * ROM_WORDS) begin
            w    = progs[p][pc];
            sel  = w.dat.r_field[1:0];
            addr = ptr[sel];
            pc   = pc + 1'b1;
            steps++;
            case (w.jmp.op)
                NOP: ;
                GOTO: pc = w.jmp.ja[`DSP_ROM_AW-1:0];
                LDI: begin
                    case (w.dat.r_field)
                        R0, R1, R2, R3: ptr[sel] = w.dat.imm[`DSP_RAM_AW-1:0];
                        X: x = {{7{w.dat.imm[8]}}, w.dat.imm};
                        Y: y = {{7{w.dat.imm[8]}}, w.dat.imm};
                        default: begin
                            end_halt  = 1'b1;
                            end_fault = 1'b1;
                        end
                    endcase
                end
                STR: begin
                    ram[addr] = a0[15:0];
                    ptr[sel]  = addr + 1'b1;
                end
                LDR: begin
                    y        = ram[addr];
                    ptr[sel] = addr + 1'b1;
                end
                MAC: begin
                    prod = 32'(x) * 32'(y);
                    a0   = a0 + 36'(prod);
                end
                OUT:  outs.push_back(a0[15:0]);
                HALT: end_halt = 1'b1;
                CLR:  a0 = '0;
                default: begin
                    end_halt  = 1'b1;
                    end_fault = 1'b1;
                end
            endcase
        end
    endfunction

    task automatic build_programs();
        // Test 1: single product
        append_word(0, data_word(LDI, X, rand_imm()));
        append_word(0, data_word(LDI, Y, rand_imm()));
        append_word(0, op_word(CLR));
        append_word(0, op_word(MAC));
        append_word(0, op_word(OUT));
        append_word(0, op_word(HALT));
        // Test 2: running sum, last OUT repeated back to back
        append_word(1, op_word(CLR));
        repeat (4) begin
            append_word(1, data_word(LDI, X, rand_imm()));
            append_word(1, data_word(LDI, Y, rand_imm()));
            append_word(1, op_word(MAC));
            append_word(1, op_word(OUT));
        end
        append_word(1, op_word(OUT));
        append_word(1, op_word(HALT));
        // Test 3: stores from address 14 wrap past 15
        append_word(2, data_word(LDI, R1, 9'd14));
        repeat (4) begin
            append_word(2, op_word(CLR));
            append_word(2, data_word(LDI, X, rand_imm()));
            append_word(2, data_word(LDI, Y, rand_imm()));
            append_word(2, op_word(MAC));
            append_word(2, data_word(STR, R1, 9'd0));
        end
        append_word(2, data_word(LDI, R1, 9'd14));
        append_word(2, data_word(LDI, X, 9'd1));
        repeat (4) begin
            append_word(2, op_word(CLR));
            append_word(2, data_word(LDR, R1, 9'd0));
            append_word(2, op_word(MAC));
            append_word(2, op_word(OUT));
        end
        append_word(2, op_word(HALT));
        // Test 4: jump over two OUTs, one OUT behind HALT
        append_word(3, op_word(CLR));
        append_word(3, data_word(LDI, X, rand_imm()));
        append_word(3, data_word(LDI, Y, rand_imm()));
        append_word(3, op_word(MAC));
        append_word(3, jump_word(8'd7));
        append_word(3, op_word(OUT));
        append_word(3, op_word(OUT));
        append_word(3, op_word(OUT));
        append_word(3, op_word(HALT));
        append_word(3, op_word(OUT));
        // Test 5: test 1 with its HALT replaced by opcode 12
        for (int a = 0; a < prog_len[0] - 1; a++) begin
            append_word(4, progs[0][a]);
        end
        append_word(4, 16'hc000);
        append_word(4, op_word(OUT));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(int p, bit rand_en);
        logic [`DSP_DATA_W-1:0] exp_q[$];
        logic                   end_halt;
        logic                   end_fault;
        ref_run(p, exp_q, end_halt, end_fault);
        if (!end_halt) begin
            tb_errors++;
            $display("Test %0d: reference program never reaches a halt", p + 1);
        end
        rst_n  = 1'b0;
        clk_en = 1'b1;
        for (int a = 0; a < prog_len[p]; a++) begin
            prog_we   = 1'b1;
            prog_addr = `DSP_ROM_AW'(a);
            prog_data = progs[p][a];
            next_cycle();
        end
        prog_we = 1'b0;
        foreach (exp_q[i]) begin
            exp_valid = 1'b1;
            exp_data  = exp_q[i];
            next_cycle();
        end
        exp_valid = 1'b0;
        exp_fault = end_fault;
        repeat (16) next_cycle();
        rst_n = 1'b1;
        while (!run_done) begin
            if (rand_en) begin
                clk_en = ($random(seed) & 1) != 0;
            end
            next_cycle();
        end
        // A few more cycles to catch strobes after the stop
        clk_en = 1'b1;
        repeat (8) next_cycle();
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: core did not finish within %0d cycles", cycle_limit);
            $display("Error counts: checker %0d, testbench %0d, assertions %0d",
                     chk_errors, tb_errors + 1, dut_i.props_i.fail_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int total;
        rst_n     = 1'b0;
        clk_en    = 1'b1;
        prog_addr = '0;
        prog_data = '0;
        prog_we   = 1'b0;
        exp_valid = 1'b0;
        exp_data  = '0;
        exp_fault = 1'b0;
        foreach (progs[p, a]) progs[p][a] = '0;
        foreach (prog_len[p]) prog_len[p] = 0;
        build_programs();
        total = 0;
        foreach (prog_len[p]) total += prog_len[p];
        cycle_limit = 4 * total + 64 * N_TESTS;
        for (int p = 0; p < N_TESTS; p++) begin
            run_test(p, p == N_TESTS - 1);
        end
        $display("Error counts: checker %0d, testbench %0d, assertions %0d",
                 chk_errors, tb_errors, dut_i.props_i.fail_count);
        if (chk_errors == 0 && tb_errors == 0 && dut_i.props_i.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+logic
logic/dsp_isa_pkg.sv
logic/dsp_bus_pkg.sv
logic/dsp_rom_aau.sv
logic/dsp_ctrl.sv
logic/dsp_ram_aau.sv
logic/dsp_dau.sv
logic/dsp_pio.sv
logic/dsp_top.sv
test/dsp_properties.sv
test/dsp_checker.sv
test/dsp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DSP core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module dsp_tb -o dsp_sim

# Assertion errors must not stop the run before the summary
./obj_dir/dsp_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi
